// ==== hdl/pcs_rx_pkg.sv ====
`default_nettype none

package pcs_rx_pkg;

    // block geometry
    localparam int LEN_CODED_BLOCK = 66;
    localparam int LEN_SCRAMBLER   = 58;
    localparam int NB_SH           = 2;
    localparam int NB_BLOCK_TYPE   = 8;
    localparam int NB_PAYLOAD      = LEN_CODED_BLOCK - NB_SH;
    localparam int NB_CTRL_BODY    = NB_PAYLOAD - NB_BLOCK_TYPE;

    // saturating error counter width
    localparam int ERR_COUNT_WIDTH = 16;

    // valid sync headers, anything else is a header error
    localparam logic [NB_SH-1:0] SYNC_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SYNC_CTRL = 2'b10;

    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } data_block_t;

    typedef struct packed {
        logic [NB_SH-1:0]         sh;
        logic [NB_BLOCK_TYPE-1:0] block_type;
        logic [NB_CTRL_BODY-1:0]  body;
    } ctrl_block_t;

    // same 66 bits seen as data or as control block
    typedef union packed {
        data_block_t data;
        ctrl_block_t ctrl;
    } coded_block_u;

    // idle block, eight zero control codes
    localparam logic [LEN_CODED_BLOCK-1:0] IDLE_BLOCK =
        {SYNC_CTRL, 8'h1E, {NB_CTRL_BODY{1'b0}}};

    // sequence ordered set, local fault
    localparam logic [LEN_CODED_BLOCK-1:0] LF_BLOCK =
        {SYNC_CTRL, 8'h4B, 8'h00, 8'h00, 8'h01, 4'h0, 28'h0000000};

    // eight 7-bit error control codes
    localparam logic [LEN_CODED_BLOCK-1:0] ERROR_BLOCK =
        {SYNC_CTRL, 8'h1E, {8{7'h1E}}};

    // descrambler to checker
    typedef struct packed {
        logic         valid;
        logic         tag;
        coded_block_u block;
    } lane_block_t;

endpackage

`default_nettype wire

// ==== hdl/frame_generator_rx.sv ====
`default_nettype none

module frame_generator_rx
    import pcs_rx_pkg::*;
#(
    parameter int IDLE_SPACING = 4
)
(
    input  wire          i_clock,
    input  wire          i_reset,
    input  wire          i_enable,
    input  wire          i_valid,
    output coded_block_u o_data
);

    localparam int PHASE_W = (IDLE_SPACING > 1) ? $clog2(IDLE_SPACING) : 1;
    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(IDLE_SPACING - 1);

    logic [PHASE_W-1:0] phase;
    logic               step;
    logic               idle_slot;

    // only blocks that really arrive consume a filler slot
    assign step      = i_enable & i_valid;
    assign idle_slot = (phase == LAST_PHASE);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            phase <= '0;
        end
        else if (step)
        begin
            if (idle_slot)
                phase <= '0;
            else
                phase <= phase + 1'b1;
        end
    end

    // local fault filler, one idle every IDLE_SPACING blocks
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_data <= '0;
        end
        else if (step)
        begin
            if (idle_slot)
                o_data <= IDLE_BLOCK;
            else
                o_data <= LF_BLOCK;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/descrambler.sv ====
`default_nettype none

module descrambler
    import pcs_rx_pkg::*;
#(
    parameter logic [LEN_SCRAMBLER-1:0] SEED         = '0,
    parameter int                       IDLE_SPACING = 4
)
(
    input  wire                       i_clock,
    input  wire                       i_reset,
    input  wire                       i_enable,
    input  wire                       i_valid,
    input  wire                       i_bypass,
    input  wire                       i_deskew_done,
    input  wire                       i_tag,
    input  wire [LEN_CODED_BLOCK-1:0] i_data,
    output lane_block_t               o_block
);

    // x^39 tap, newest bit sits at the top of the state
    localparam int TAP_39 = LEN_SCRAMBLER - 1 - 38;

    logic [LEN_SCRAMBLER-1:0] scram_state;
    logic [LEN_SCRAMBLER-1:0] state_next;
    logic [NB_PAYLOAD-1:0]    desc_payload;
    coded_block_u             data_q;
    coded_block_u             frame_generated;
    logic                     valid_q;
    logic                     tag_q;
    logic                     gen_enable;

    // bit-serial descrambling, first transmitted bit is payload bit 63
    always_comb
    begin
        state_next   = scram_state;
        desc_payload = '0;
        for (int i = NB_PAYLOAD - 1; i >= 0; i--)
        begin
            desc_payload[i] = i_data[i] ^ state_next[TAP_39] ^ state_next[0];
            state_next      = {i_data[i], state_next[LEN_SCRAMBLER-1:1]};
        end
    end

    // state freezes in bypass
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            scram_state <= SEED;
        else if (i_enable && !i_bypass)
            scram_state <= state_next;
    end

    // sync header is never scrambled
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            data_q <= '0;
        else if (i_enable && i_bypass)
            data_q <= i_data;
        else if (i_enable)
            data_q <= {i_data[LEN_CODED_BLOCK-1 -: NB_SH], desc_payload};
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            valid_q <= 1'b0;
        else if (i_enable)
            valid_q <= i_valid;
    end

    // tag holds through gaps in valid
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            tag_q <= 1'b0;
        else if (i_enable && i_valid)
            tag_q <= i_tag;
    end

    // filler only runs while the lane is not deskewed
    assign gen_enable = i_enable & ~i_deskew_done;

    frame_generator_rx
    #(
        .IDLE_SPACING (IDLE_SPACING)
    )
    u_frame_generator_rx
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (gen_enable),
        .i_valid  (i_valid),
        .o_data   (frame_generated)
    );

    assign o_block.valid = valid_q;
    assign o_block.tag   = tag_q;
    assign o_block.block = i_deskew_done ? data_q : frame_generated;

endmodule

`default_nettype wire

// ==== hdl/block_type_checker.sv ====
`default_nettype none

module block_type_checker
    import pcs_rx_pkg::*;
(
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_enable,
    input  wire lane_block_t           i_block,
    output lane_block_t                o_block,
    output logic [ERR_COUNT_WIDTH-1:0] o_error_count
);

    logic [NB_SH-1:0]         sync_header;
    logic [NB_BLOCK_TYPE-1:0] block_type;
    logic                     sh_error;
    logic                     type_error;
    logic                     block_error;
    logic                     count_full;

    // legal 64b/66b control block types
    function automatic logic is_legal_type(input logic [NB_BLOCK_TYPE-1:0] btype);
        logic legal;
        case (btype)
            8'h1E, 8'h2D, 8'h33, 8'h66, 8'h55,
            8'h78, 8'h4B, 8'h87, 8'h99, 8'hAA,
            8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF:
                legal = 1'b1;
            default:
                legal = 1'b0;
        endcase
        return legal;
    endfunction

    // header from the data view, type from the control view
    assign sync_header = i_block.block.data.sh;
    assign block_type  = i_block.block.ctrl.block_type;

    assign sh_error    = (sync_header != SYNC_DATA) && (sync_header != SYNC_CTRL);
    assign type_error  = (sync_header == SYNC_CTRL) && !is_legal_type(block_type);

    // gaps in valid are never checked
    assign block_error = i_block.valid && (sh_error || type_error);

    assign count_full  = &o_error_count;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_block <= '0;
        end
        else if (i_enable)
        begin
            o_block.valid <= i_block.valid;
            o_block.tag   <= i_block.tag;
            if (block_error)
                o_block.block <= ERROR_BLOCK;
            else
                o_block.block <= i_block.block;
        end
    end

    // counter sticks at all ones
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_error_count <= '0;
        else if (i_enable && block_error && !count_full)
            o_error_count <= o_error_count + 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/pcs_rx_lane.sv ====
`default_nettype none

module pcs_rx_lane
    import pcs_rx_pkg::*;
#(
    parameter logic [LEN_SCRAMBLER-1:0] SEED         = '0,
    parameter int                       IDLE_SPACING = 4
)
(
    input  wire                        i_clock,
    input  wire                        i_reset,
    input  wire                        i_enable,
    input  wire                        i_valid,
    input  wire                        i_bypass,
    input  wire                        i_deskew_done,
    input  wire [LEN_CODED_BLOCK-1:0]  i_data,
    input  wire                        i_tag,
    output lane_block_t                o_block,
    output logic [ERR_COUNT_WIDTH-1:0] o_error_count
);

    // descrambled lane, or filler before deskew
    lane_block_t desc_out;

    descrambler
    #(
        .SEED         (SEED),
        .IDLE_SPACING (IDLE_SPACING)
    )
    u_descrambler
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_valid       (i_valid),
        .i_bypass      (i_bypass),
        .i_deskew_done (i_deskew_done),
        .i_tag         (i_tag),
        .i_data        (i_data),
        .o_block       (desc_out)
    );

    block_type_checker
    u_block_type_checker
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_block       (desc_out),
        .o_block       (o_block),
        .o_error_count (o_error_count)
    );

endmodule

`default_nettype wire

// ==== verification/pcs_rx_lane_asserts.sv ====
`default_nettype none

module pcs_rx_lane_asserts
    import pcs_rx_pkg::*;
(
    input wire                       i_clock,
    input wire                       i_reset,
    input wire                       i_enable,
    input wire lane_block_t          o_block,
    input wire [ERR_COUNT_WIDTH-1:0] o_error_count
);

    // outputs clear on the edge that sees reset
    property reset_clears_outputs;
        @(posedge i_clock)
        i_reset |=> (o_block == '0) && (o_error_count == '0);
    endproperty

    // nothing advances in a stall
    property stall_holds_outputs;
        @(posedge i_clock)
        (!i_enable && !i_reset) |=> $stable(o_block) && $stable(o_error_count);
    endproperty

    property count_never_drops;
        @(posedge i_clock)
        !i_reset |=> (o_error_count >= $past(o_error_count));
    endproperty

    reset_clears_outputs_a : assert property (reset_clears_outputs)
    else
        $error("outputs not cleared one cycle after reset");

    stall_holds_outputs_a : assert property (stall_holds_outputs)
    else
        $error("outputs changed during a stall cycle");

    count_never_drops_a : assert property (count_never_drops)
    else
        $error("error count decreased without reset");

endmodule

bind pcs_rx_lane pcs_rx_lane_asserts u_pcs_rx_lane_asserts
(
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_enable      (i_enable),
    .o_block       (o_block),
    .o_error_count (o_error_count)
);

`default_nettype wire

// ==== verification/pcs_rx_lane_tb.sv ====
`default_nettype none

module pcs_rx_lane_tb
    import pcs_rx_pkg::*;
;

    localparam int CLOCK_HALF   = 20;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_SPACING = 4;
    localparam logic [LEN_SCRAMBLER-1:0] SEED = 58'h2_F03C_5A9E_47B2_1D;

    // cycles per test section
    localparam int N_PRE    = 32;
    localparam int N_FLUSH  = 3;
    localparam int N_DESC   = 40;
    localparam int N_BYP    = 16;
    localparam int N_AFTER  = 16;
    localparam int N_ERR    = 32;
    localparam int N_STALL  = 48;
    localparam int N_SPARSE = 48;
    localparam int N_DRAIN  = 8;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_PRE + N_FLUSH + N_DESC + N_BYP + N_AFTER
                                + N_ERR + N_STALL + N_SPARSE + N_DRAIN;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 100;

    localparam int KIND_DATA     = 0;
    localparam int KIND_CTRL     = 1;
    localparam int KIND_SH_00    = 2;
    localparam int KIND_SH_11    = 3;
    localparam int KIND_BAD_TYPE = 4;

    localparam logic [7:0] LEGAL_TYPES [15] = '{
        8'h1E, 8'h2D, 8'h33, 8'h66, 8'h55, 8'h78, 8'h4B, 8'h87,
        8'h99, 8'hAA, 8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF
    };

    logic                       i_clock;
    logic                       i_reset;
    logic                       i_enable;
    logic                       i_valid;
    logic                       i_bypass;
    logic                       i_deskew_done;
    logic [LEN_CODED_BLOCK-1:0] i_data;
    logic                       i_tag;
    lane_block_t                o_block;
    logic [ERR_COUNT_WIDTH-1:0] o_error_count;

    integer                     seed = 32'h12af_ac3d;
    logic [LEN_SCRAMBLER-1:0]   line_state = SEED;
    int                         gen_phase = 0;
    logic [ERR_COUNT_WIDTH-1:0] exp_count = '0;
    logic                       last_tag = 1'b0;
    lane_block_t                exp_blocks [$];
    logic [ERR_COUNT_WIDTH-1:0] exp_counts [$];

    pcs_rx_lane
    #(
        .SEED         (SEED),
        .IDLE_SPACING (IDLE_SPACING)
    )
    dut_i
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_valid       (i_valid),
        .i_bypass      (i_bypass),
        .i_deskew_done (i_deskew_done),
        .i_data        (i_data),
        .i_tag         (i_tag),
        .o_block       (o_block),
        .o_error_count (o_error_count)
    );

    initial
    begin
        i_clock = 1'b0;
        forever
            #CLOCK_HALF i_clock = ~i_clock;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic type_is_legal(input logic [7:0] btype);
        logic found;
        found = 1'b0;
        foreach (LEGAL_TYPES[i])
            if (LEGAL_TYPES[i] == btype)
                found = 1'b1;
        return found;
    endfunction

    // transmit scrambler with line bits fed back and the newest bit at the top
    function automatic logic [NB_PAYLOAD-1:0] scramble_payload(
        input  logic [LEN_SCRAMBLER-1:0] state_in,
        input  logic [NB_PAYLOAD-1:0]    plain,
        output logic [LEN_SCRAMBLER-1:0] state_out
    );
        logic [LEN_SCRAMBLER-1:0] st;
        logic [NB_PAYLOAD-1:0]    line;
        st   = state_in;
        line = '0;
        for (int i = NB_PAYLOAD - 1; i >= 0; i--)
        begin
            // x^39 and x^58 taps
            line[i] = plain[i] ^ st[LEN_SCRAMBLER-39] ^ st[LEN_SCRAMBLER-58];
            st      = {line[i], st[LEN_SCRAMBLER-1:1]};
        end
        state_out = st;
        return line;
    endfunction

    // expected output for one accepted block
    function automatic lane_block_t model_block(
        input  logic         deskewed,
        input  int           phase,
        input  coded_block_u plain,
        input  logic         tag,
        output logic         bad
    );
        lane_block_t      res;
        logic [NB_SH-1:0] sh;
        sh        = plain.data.sh;
        res.valid = 1'b1;
        res.tag   = tag;
        bad       = 1'b0;
        if (!deskewed)
        begin
            if (phase == IDLE_SPACING - 1)
                res.block = IDLE_BLOCK;
            else
                res.block = LF_BLOCK;
        end
        else
        begin
            if (sh == 2'b00 || sh == 2'b11)
                bad = 1'b1;
            else if (sh == SYNC_CTRL && !type_is_legal(plain.ctrl.block_type))
                bad = 1'b1;
            if (bad)
                res.block = ERROR_BLOCK;
            else
                res.block = plain;
        end
        return res;
    endfunction

    function automatic coded_block_u random_block(input int kind);
        coded_block_u          blk;
        logic [NB_PAYLOAD-1:0] payload;
        logic [31:0]           pick;
        logic [7:0]            btype;
        int                    idx;
        payload = {next_random(), next_random()};
        pick    = next_random();
        idx     = int'(pick[7:0]) % 15;
        btype   = LEGAL_TYPES[idx];
        case (kind)
            KIND_DATA:  blk = {SYNC_DATA, payload};
            KIND_CTRL:  blk = {SYNC_CTRL, btype, payload[NB_CTRL_BODY-1:0]};
            KIND_SH_00: blk = {2'b00, payload};
            KIND_SH_11: blk = {2'b11, payload};
            default:
            begin
                btype = pick[15:8];
                while (type_is_legal(btype))
                begin
                    pick  = next_random();
                    btype = pick[7:0];
                end
                blk = {SYNC_CTRL, btype, payload[NB_CTRL_BODY-1:0]};
            end
        endcase
        return blk;
    endfunction

    // roughly three in eight blocks are malformed
    function automatic int error_mix_kind(input logic [2:0] sel);
        int k;
        k = int'(sel);
        if (k > KIND_BAD_TYPE)
            k = KIND_CTRL;
        return k;
    endfunction

    task automatic report_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_block(input string name, input lane_block_t got, input lane_block_t want);
        if (got !== want)
        begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, want, got);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input logic [ERR_COUNT_WIDTH-1:0] got,
                               input logic [ERR_COUNT_WIDTH-1:0] want);
        if (got !== want)
        begin
            $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, want, got);
            report_failure();
        end
    endtask

    task automatic check_tag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
                     $time, name, want, got);
            report_failure();
        end
    endtask

    // one stimulus cycle that queues the expected result of an accepted block
    task automatic drive_cycle(input logic en, input logic vld, input logic byp,
                               input logic dsk, input coded_block_u plain, input logic tag);
        logic [LEN_SCRAMBLER-1:0] state_after;
        logic [NB_PAYLOAD-1:0]    raw_payload;
        lane_block_t              want;
        logic                     bad;
        @(posedge i_clock);
        #DRIVE_DELAY;
        raw_payload   = scramble_payload(line_state, plain.data.payload, state_after);
        i_enable      = en;
        i_valid       = vld;
        i_bypass      = byp;
        i_deskew_done = dsk;
        i_tag         = tag;
        if (byp)
            i_data = plain;
        else
            i_data = {plain.data.sh, raw_payload};
        if (en && !byp)
            line_state = state_after;
        if (en && vld)
        begin
            want = model_block(dsk, gen_phase, plain, tag, bad);
            if (bad && exp_count != '1)
                exp_count = exp_count + 1'b1;
            exp_blocks.push_back(want);
            exp_counts.push_back(exp_count);
            if (!dsk)
                gen_phase = (gen_phase + 1) % IDLE_SPACING;
        end
    endtask

    task automatic drive_random(input logic en, input logic vld, input logic byp,
                                input logic dsk, input int kind);
        logic [31:0] r;
        r = next_random();
        drive_cycle(en, vld, byp, dsk, random_block(kind), r[0]);
    endtask

    initial
    begin : stimulus
        logic [31:0] r;
        i_reset       = 1'b1;
        i_enable      = 1'b0;
        i_valid       = 1'b0;
        i_bypass      = 1'b0;
        i_deskew_done = 1'b0;
        i_data        = '0;
        i_tag         = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        #DRIVE_DELAY;
        i_reset = 1'b0;

        // filler before deskew with stalls and gaps in valid
        repeat (N_PRE)
        begin
            r = next_random();
            drive_random(r[3:2] != 2'b00, r[4] | r[5], 1'b0, 1'b0,
                         r[0] ? KIND_CTRL : KIND_DATA);
        end
        // empty pipeline before deskew goes high
        repeat (N_FLUSH) drive_random(1'b1, 1'b0, 1'b0, 1'b0, KIND_DATA);

        repeat (N_DESC)
        begin
            r = next_random();
            drive_random(1'b1, 1'b1, 1'b0, 1'b1, r[0] ? KIND_CTRL : KIND_DATA);
        end

        // bypass then scrambling resumes from the frozen state
        repeat (N_BYP)
        begin
            r = next_random();
            drive_random(1'b1, 1'b1, 1'b1, 1'b1, r[0] ? KIND_CTRL : KIND_DATA);
        end
        repeat (N_AFTER)
        begin
            r = next_random();
            drive_random(1'b1, 1'b1, 1'b0, 1'b1, r[0] ? KIND_CTRL : KIND_DATA);
        end

        repeat (N_ERR)
        begin
            r = next_random();
            drive_random(1'b1, 1'b1, 1'b0, 1'b1, error_mix_kind(r[2:0]));
        end

        // random stalls
        repeat (N_STALL)
        begin
            r = next_random();
            drive_random(r[1:0] != 2'b00, 1'b1, 1'b0, 1'b1, error_mix_kind(r[4:2]));
        end

        // gaps in valid
        repeat (N_SPARSE)
        begin
            r = next_random();
            drive_random(1'b1, r[0], 1'b0, 1'b1, error_mix_kind(r[3:1]));
        end

        while (exp_blocks.size() != 0)
            drive_random(1'b1, 1'b0, 1'b0, 1'b1, KIND_DATA);

        if (o_error_count !== exp_count)
        begin
            $display("CHECK FAILED time=%0t signal=o_error_count expected=%0d actual=%0d",
                     $time, exp_count, o_error_count);
            report_failure();
        end
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

    initial
    begin : compare_outputs
        logic                       edge_enabled;
        logic                       edge_reset;
        lane_block_t                want_block;
        logic [ERR_COUNT_WIDTH-1:0] want_count;
        forever
        begin
            @(posedge i_clock);
            edge_enabled = i_enable;
            edge_reset   = i_reset;
            // outputs settled by the falling edge
            @(negedge i_clock);
            if (edge_reset)
            begin
                last_tag = 1'b0;
            end
            else if (edge_enabled && o_block.valid)
            begin
                if (exp_blocks.size() == 0)
                begin
                    $display("valid output block at time %0t with no expected block queued",
                             $time);
                    report_failure();
                end
                else
                begin
                    want_block = exp_blocks.pop_front();
                    want_count = exp_counts.pop_front();
                    check_block("o_block", o_block, want_block);
                    check_count("o_error_count", o_error_count, want_count);
                    last_tag = o_block.tag;
                end
            end
            else if (edge_enabled)
            begin
                check_tag("o_block.tag", o_block.tag, last_tag);
            end
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge i_clock);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_failure();
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/pcs_rx_pkg.sv
hdl/frame_generator_rx.sv
hdl/descrambler.sv
hdl/block_type_checker.sv
hdl/pcs_rx_lane.sv
verification/pcs_rx_lane_asserts.sv
verification/pcs_rx_lane_tb.sv

// ==== Makefile ====
# Verilator build and run for the PCS receive lane testbench

VERILATOR  ?= verilator
TOP        ?= pcs_rx_lane_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
RUN_ARGS   ?=

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(SIM_EXE) $(RUN_ARGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
